/* source/i2c_pkg.sv */
// I2C master shared definitions
// Register map, bit positions, clock presets and bus response codes
package i2c_pkg;

  localparam int AXI_ADDR_W = 8;
  localparam int AXI_DATA_W = 32;
  // Word address carried on the internal register bus
  localparam int REG_ADDR_W = AXI_ADDR_W - 2;
  localparam int DIV_W      = 16;

  localparam logic [31:0] CLOCK_RATE = 32'd50_000_000;

  // Four phases per SCL period
  localparam logic [DIV_W-1:0] DIV_100KHZ = DIV_W'(CLOCK_RATE / (4 * 100_000) - 1);
  localparam logic [DIV_W-1:0] DIV_400KHZ = DIV_W'(CLOCK_RATE / (4 * 400_000) - 1);

  localparam logic [REG_ADDR_W-1:0] REG_CONTROL       = 6'd0;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS        = 6'd1;
  localparam logic [REG_ADDR_W-1:0] REG_INTERRUPT     = 6'd2;
  localparam logic [REG_ADDR_W-1:0] REG_INTERRUPT_EN  = 6'd3;
  localparam logic [REG_ADDR_W-1:0] REG_CLOCK_RATE    = 6'd4;
  localparam logic [REG_ADDR_W-1:0] REG_CLOCK_DIVIDER = 6'd5;
  localparam logic [REG_ADDR_W-1:0] REG_COMMAND       = 6'd6;
  localparam logic [REG_ADDR_W-1:0] REG_TRANSMIT      = 6'd7;
  localparam logic [REG_ADDR_W-1:0] REG_RECEIVE       = 6'd8;
  localparam logic [REG_ADDR_W-1:0] REG_VERSION       = 6'd9;
  localparam logic [REG_ADDR_W-1:0] REG_LAST          = REG_VERSION;

  // Command register
  localparam int CMD_START = 0;
  localparam int CMD_STOP  = 1;
  localparam int CMD_READ  = 2;
  localparam int CMD_WRITE = 3;
  localparam int CMD_ACK   = 4;

  // Control register
  localparam int CTL_ENABLE   = 0;
  localparam int CTL_IEN      = 1;
  localparam int CTL_SET_100K = 2;
  localparam int CTL_SET_400K = 3;
  localparam int CTL_SW_CLEAR = 7;

  // Status register
  localparam int STS_RXACK = 7;
  localparam int STS_BUSY  = 6;
  localparam int STS_TIP   = 1;

  // Interrupt pending and enable
  localparam int INT_DONE = 0;
  localparam int INT_NACK = 2;

  // Major 1, minor 0, revision 0
  localparam logic [31:0] VERSION_WORD = 32'h1000_0000;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* source/reg_bus_if.sv */
// Register strobe bus between the AXI-Lite front end and the register file
// Requests are levels held until a one-cycle acknowledge
interface reg_bus_if
  import i2c_pkg::*;
();

  logic [REG_ADDR_W-1:0] address;
  logic                  wr_req;
  logic [AXI_DATA_W-1:0] wr_data;
  logic                  rd_req;
  logic                  wr_ack;
  logic                  rd_ack;
  logic [AXI_DATA_W-1:0] rd_data;
  // Qualified by either acknowledge
  logic                  invalid;

  modport slave (
    output address, wr_req, wr_data, rd_req,
    input  wr_ack, rd_ack, rd_data, invalid
  );

  modport register (
    input  address, wr_req, wr_data, rd_req,
    output wr_ack, rd_ack, rd_data, invalid
  );

endinterface

/* source/axi_lite_reg_slave.sv */
// AXI-Lite slave front end
// Turns write and read channel transfers into register bus requests
// and returns OKAY or SLVERR from the register file's invalid flag
module axi_lite_reg_slave
  import i2c_pkg::*;
(
  input  logic                  clk,
  input  logic                  core_reset,

  input  logic                  i_awvalid,
  input  logic [AXI_ADDR_W-1:0] i_awaddr,
  output logic                  o_awready,
  input  logic                  i_wvalid,
  input  logic [AXI_DATA_W-1:0] i_wdata,
  output logic                  o_wready,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output logic [1:0]            o_bresp,

  input  logic                  i_arvalid,
  input  logic [AXI_ADDR_W-1:0] i_araddr,
  output logic                  o_arready,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [1:0]            o_rresp,
  output logic [AXI_DATA_W-1:0] o_rdata,

  reg_bus_if.slave              bus
);

  logic                  w_pend;
  logic                  r_pend;
  logic                  w_accept;
  logic                  r_accept;
  logic [REG_ADDR_W-1:0] w_addr;
  logic [REG_ADDR_W-1:0] r_addr;
  logic [AXI_DATA_W-1:0] w_data;

  // Only one request is up at a time, so the shared address never moves
  // under a pending request. A write wins a same-cycle tie.
  assign w_accept = i_awvalid && i_wvalid && !w_pend && !o_bvalid && !r_pend;
  assign r_accept = i_arvalid && !r_pend && !o_rvalid && !w_pend && !w_accept;

  assign o_awready = w_accept;
  assign o_wready  = w_accept;
  assign o_arready = r_accept;

  assign bus.wr_req  = w_pend;
  assign bus.rd_req  = r_pend;
  assign bus.wr_data = w_data;
  assign bus.address = w_pend ? w_addr : r_addr;

  // Write channel sequencing
  always_ff @(posedge clk) begin
    if (core_reset) begin
      w_pend   <= 1'b0;
      o_bvalid <= 1'b0;
    end else begin
      if (w_accept) begin
        w_pend <= 1'b1;
      end else if (bus.wr_ack) begin
        w_pend   <= 1'b0;
        o_bvalid <= 1'b1;
      end else if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  // Read channel sequencing
  always_ff @(posedge clk) begin
    if (core_reset) begin
      r_pend   <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (r_accept) begin
        r_pend <= 1'b1;
      end else if (bus.rd_ack) begin
        r_pend   <= 1'b0;
        o_rvalid <= 1'b1;
      end else if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // Latched addresses, data and responses
  always_ff @(posedge clk) begin
    if (w_accept) begin
      w_addr <= i_awaddr[AXI_ADDR_W-1:2];
      w_data <= i_wdata;
    end
    if (r_accept) begin
      r_addr <= i_araddr[AXI_ADDR_W-1:2];
    end
    if (bus.wr_ack) begin
      o_bresp <= bus.invalid ? RESP_SLVERR : RESP_OKAY;
    end
    if (bus.rd_ack) begin
      o_rresp <= bus.invalid ? RESP_SLVERR : RESP_OKAY;
      o_rdata <= bus.rd_data;
    end
  end

  // A response always follows an acknowledged request
  a_resp_after_req: assert property (@(posedge clk) disable iff (core_reset)
    ($rose(o_bvalid) |-> $past(bus.wr_req && bus.wr_ack)) and
    ($rose(o_rvalid) |-> $past(bus.rd_req && bus.rd_ack)));

  a_addr_stable: assert property (@(posedge clk) disable iff (core_reset)
    ((bus.wr_req && $past(bus.wr_req)) || (bus.rd_req && $past(bus.rd_req)))
    |-> $stable(bus.address));

endmodule

/* source/i2c_reg_file.sv */
// I2C master register file
// Decodes register bus requests, holds control and command state,
// builds status and raises interrupts from byte engine events
module i2c_reg_file
  import i2c_pkg::*;
(
  input  logic             clk,
  input  logic             core_reset,
  reg_bus_if.register      bus,

  output logic [4:0]       o_cmd,
  output logic             o_enable,
  output logic [DIV_W-1:0] o_clk_div,
  output logic [7:0]       o_tx_byte,
  output logic             o_sw_clear,
  input  logic             i_done,
  input  logic             i_rx_ack,
  input  logic [7:0]       i_rx_byte,
  input  logic             i_busy,
  output logic             o_interrupt
);

  logic [7:0]       control;
  logic [4:0]       command;
  logic [7:0]       transmit;
  logic [DIV_W-1:0] clk_div;
  logic [7:0]       int_pend;
  logic [7:0]       int_en;
  logic [7:0]       status;
  logic             rxack;
  logic             tip;
  logic             wr_go;
  logic             rd_go;

  // Serve each request once; writes first
  assign wr_go = bus.wr_req && !bus.wr_ack;
  assign rd_go = bus.rd_req && !bus.rd_ack && !wr_go;

  assign tip = command[CMD_READ] | command[CMD_WRITE];

  always_comb begin
    status = '0;
    status[STS_RXACK] = rxack;
    status[STS_BUSY]  = i_busy;
    status[STS_TIP]   = tip;
  end

  assign o_cmd       = command;
  assign o_enable    = control[CTL_ENABLE];
  assign o_sw_clear  = control[CTL_SW_CLEAR];
  assign o_clk_div   = clk_div;
  assign o_tx_byte   = transmit;
  assign o_interrupt = control[CTL_IEN] & (|(int_pend & int_en));

  always_ff @(posedge clk) begin
    if (core_reset) begin
      bus.wr_ack <= 1'b0;
      bus.rd_ack <= 1'b0;
      control    <= 8'(1 << CTL_ENABLE);
      command    <= '0;
      transmit   <= '0;
      clk_div    <= DIV_100KHZ;
      int_pend   <= '0;
      int_en     <= '0;
      rxack      <= 1'b0;
    end else begin
      bus.wr_ack <= wr_go;
      bus.rd_ack <= rd_go;
      rxack      <= i_rx_ack;

      // One-shot control bits
      if (control[CTL_SET_100K]) begin
        clk_div               <= DIV_100KHZ;
        control[CTL_SET_100K] <= 1'b0;
      end
      if (control[CTL_SET_400K]) begin
        clk_div               <= DIV_400KHZ;
        control[CTL_SET_400K] <= 1'b0;
      end
      control[CTL_SW_CLEAR] <= 1'b0;

      if (wr_go) begin
        case (bus.address)
          REG_CONTROL:       control  <= bus.wr_data[7:0];
          REG_INTERRUPT:     int_pend <= int_pend & ~bus.wr_data[7:0];
          REG_INTERRUPT_EN:  int_en   <= bus.wr_data[7:0];
          REG_CLOCK_DIVIDER: clk_div  <= bus.wr_data[DIV_W-1:0];
          REG_COMMAND:       command  <= bus.wr_data[4:0];
          REG_TRANSMIT:      transmit <= bus.wr_data[7:0];
          default: ;
        endcase
      end

      // Transfer end wins over a write in the same cycle
      if (i_done) begin
        command[3:0]       <= '0;
        int_pend[INT_DONE] <= 1'b1;
        if (i_rx_ack) begin
          int_pend[INT_NACK] <= 1'b1;
        end
      end
    end
  end

  // Read data and address check
  always_ff @(posedge clk) begin
    if (rd_go) begin
      case (bus.address)
        REG_CONTROL:       bus.rd_data <= {24'h0, control};
        REG_STATUS:        bus.rd_data <= {24'h0, status};
        REG_INTERRUPT:     bus.rd_data <= {24'h0, int_pend};
        REG_INTERRUPT_EN:  bus.rd_data <= {24'h0, int_en};
        REG_CLOCK_RATE:    bus.rd_data <= CLOCK_RATE;
        REG_CLOCK_DIVIDER: bus.rd_data <= {16'h0, clk_div};
        REG_COMMAND:       bus.rd_data <= {27'h0, command};
        REG_TRANSMIT:      bus.rd_data <= {24'h0, transmit};
        REG_RECEIVE:       bus.rd_data <= {24'h0, i_rx_byte};
        REG_VERSION:       bus.rd_data <= VERSION_WORD;
        default:           bus.rd_data <= '0;
      endcase
    end
    if (wr_go || rd_go) begin
      bus.invalid <= (bus.address > REG_LAST);
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (core_reset)
    !(bus.wr_ack && bus.rd_ack));

  // Engine sees the command drop right after it reports done
  a_cmd_cleared: assert property (@(posedge clk) disable iff (core_reset)
    i_done |=> (o_cmd[3:0] == 4'b0));

endmodule

/* source/i2c_byte_engine.sv */
// I2C byte engine
// Walks optional START, eight data bits, ACK and optional STOP on
// open-drain SCL and SDA, four divider phases per bit
module i2c_byte_engine
  import i2c_pkg::*;
(
  input  logic             clk,
  input  logic             core_reset,
  input  logic             i_sw_clear,
  input  logic             i_enable,
  input  logic [DIV_W-1:0] i_clk_div,
  input  logic [4:0]       i_cmd,
  input  logic [7:0]       i_tx_byte,
  output logic             o_done,
  output logic             o_rx_ack,
  output logic [7:0]       o_rx_byte,
  output logic             o_busy,
  output logic             o_scl_out,
  output logic             o_scl_tri,
  input  logic             i_scl_in,
  output logic             o_sda_out,
  output logic             o_sda_tri,
  input  logic             i_sda_in
);

  // Slot 0 is START, 1 to 8 data MSB first, 9 ACK, 10 STOP
  logic [3:0]       slot;
  logic [1:0]       phase;
  logic [DIV_W-1:0] cnt;
  logic             run;
  logic [7:0]       tx_q;
  logic             scl_m;
  logic             scl_s;
  logic             sda_m;
  logic             sda_s;
  logic             sda_d;
  logic             rw;
  logic             wr;
  logic             go;
  logic             tick;
  logic             finish;
  logic             sample;
  logic [3:0]       first_slot;
  logic [3:0]       nxt_slot;
  logic [3:0]       step_slot;
  logic [1:0]       step_phase;

  // Returns {scl_release, sda_release} for a slot and phase
  function automatic logic [1:0] pin_drive(
    input logic [3:0] s,
    input logic [1:0] p,
    input logic       scl_now,
    input logic       wr_bit,
    input logic       nack,
    input logic [7:0] tx
  );
    logic scl_high;
    scl_high = (p == 2'd1) || (p == 2'd2);
    case (s)
      4'd0: begin
        case (p)
          2'd0:    pin_drive = {scl_now, 1'b1};
          2'd1:    pin_drive = 2'b11;
          2'd2:    pin_drive = 2'b10;
          default: pin_drive = 2'b00;
        endcase
      end
      4'd9: pin_drive = {scl_high, wr_bit ? 1'b1 : nack};
      4'd10: begin
        case (p)
          2'd0:    pin_drive = 2'b00;
          2'd1:    pin_drive = 2'b10;
          default: pin_drive = 2'b11;
        endcase
      end
      default: pin_drive = {scl_high, wr_bit ? tx[3'(4'd8 - s)] : 1'b1};
    endcase
  endfunction

  assign o_scl_out = 1'b0;
  assign o_sda_out = 1'b0;

  assign rw   = i_cmd[CMD_READ] | i_cmd[CMD_WRITE];
  assign wr   = i_cmd[CMD_WRITE];
  assign go   = i_enable && !run && !o_done && (|i_cmd[3:0]);
  assign tick = run && i_enable && (cnt == '0);
  // Mid-high point of SCL
  assign sample = tick && (phase == 2'd1);

  assign first_slot = i_cmd[CMD_START] ? 4'd0 : (rw ? 4'd1 : 4'd10);

  always_comb begin
    nxt_slot = slot + 4'd1;
    finish   = 1'b0;
    if (slot == 4'd0) begin
      if (rw) begin
        nxt_slot = 4'd1;
      end else if (i_cmd[CMD_STOP]) begin
        nxt_slot = 4'd10;
      end else begin
        finish = 1'b1;
      end
    end else if (slot == 4'd9) begin
      if (i_cmd[CMD_STOP]) begin
        nxt_slot = 4'd10;
      end else begin
        finish = 1'b1;
      end
    end else if (slot == 4'd10) begin
      finish = 1'b1;
    end
    step_slot  = (phase == 2'd3) ? nxt_slot : slot;
    step_phase = phase + 2'd1;
  end

  always_ff @(posedge clk) begin
    if (core_reset || i_sw_clear) begin
      run       <= 1'b0;
      slot      <= '0;
      phase     <= '0;
      cnt       <= '0;
      o_done    <= 1'b0;
      o_rx_ack  <= 1'b0;
      o_scl_tri <= 1'b1;
      o_sda_tri <= 1'b1;
    end else begin
      o_done <= 1'b0;
      if (go) begin
        run   <= 1'b1;
        slot  <= first_slot;
        phase <= 2'd0;
        cnt   <= i_clk_div;
        {o_scl_tri, o_sda_tri} <= pin_drive(first_slot, 2'd0, o_scl_tri, wr,
                                            i_cmd[CMD_ACK], i_tx_byte);
      end else if (tick) begin
        cnt <= i_clk_div;
        if (phase == 2'd3 && finish) begin
          run    <= 1'b0;
          o_done <= 1'b1;
        end else begin
          slot  <= step_slot;
          phase <= step_phase;
          {o_scl_tri, o_sda_tri} <= pin_drive(step_slot, step_phase, o_scl_tri, wr,
                                              i_cmd[CMD_ACK], tx_q);
        end
        // Slave's ACK on a write
        if (sample && slot == 4'd9 && wr) begin
          o_rx_ack <= sda_s;
        end
      end else if (run && i_enable) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Transmit byte and receive shift register
  always_ff @(posedge clk) begin
    if (go) begin
      tx_q <= i_tx_byte;
    end
    if (sample && !wr && slot >= 4'd1 && slot <= 4'd8) begin
      o_rx_byte <= {o_rx_byte[6:0], sda_s};
    end
  end

  // Pin synchronizers and bus busy from START and STOP conditions
  always_ff @(posedge clk) begin
    if (core_reset || i_sw_clear) begin
      scl_m  <= 1'b1;
      scl_s  <= 1'b1;
      sda_m  <= 1'b1;
      sda_s  <= 1'b1;
      sda_d  <= 1'b1;
      o_busy <= 1'b0;
    end else begin
      scl_m <= i_scl_in;
      scl_s <= scl_m;
      sda_m <= i_sda_in;
      sda_s <= sda_m;
      sda_d <= sda_s;
      if (scl_s && sda_d && !sda_s) begin
        o_busy <= 1'b1;
      end else if (scl_s && !sda_d && sda_s) begin
        o_busy <= 1'b0;
      end
    end
  end

  // Data and ACK slots move SDA only with SCL held low
  a_sda_on_scl_low: assert property (@(posedge clk) disable iff (core_reset)
    $changed(o_sda_tri) && !$past(i_sw_clear) && slot != 4'd0 && slot != 4'd10
    |-> !o_scl_tri && !$past(o_scl_tri));

endmodule

/* source/i2c_master_top.sv */
// I2C master with AXI-Lite register access
// Connects the AXI front end, register file and byte engine
module i2c_master_top
  import i2c_pkg::*;
(
  input  logic                  clk,
  input  logic                  core_reset,

  input  logic                  i_awvalid,
  input  logic [AXI_ADDR_W-1:0] i_awaddr,
  output logic                  o_awready,
  input  logic                  i_wvalid,
  input  logic [AXI_DATA_W-1:0] i_wdata,
  output logic                  o_wready,
  output logic                  o_bvalid,
  input  logic                  i_bready,
  output logic [1:0]            o_bresp,

  input  logic                  i_arvalid,
  input  logic [AXI_ADDR_W-1:0] i_araddr,
  output logic                  o_arready,
  output logic                  o_rvalid,
  input  logic                  i_rready,
  output logic [1:0]            o_rresp,
  output logic [AXI_DATA_W-1:0] o_rdata,

  output logic                  o_scl_out,
  output logic                  o_scl_tri,
  input  logic                  i_scl_in,
  output logic                  o_sda_out,
  output logic                  o_sda_tri,
  input  logic                  i_sda_in,

  output logic                  o_interrupt
);

  logic [4:0]       cmd;
  logic             enable;
  logic [DIV_W-1:0] clk_div;
  logic [7:0]       tx_byte;
  logic             sw_clear;
  logic             done;
  logic             rx_ack;
  logic [7:0]       rx_byte;
  logic             busy;

  reg_bus_if reg_bus ();

  axi_lite_reg_slave axi_lite_reg_slave_i (
    .clk        (clk),
    .core_reset (core_reset),
    .i_awvalid  (i_awvalid),
    .i_awaddr   (i_awaddr),
    .o_awready  (o_awready),
    .i_wvalid   (i_wvalid),
    .i_wdata    (i_wdata),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_bresp    (o_bresp),
    .i_arvalid  (i_arvalid),
    .i_araddr   (i_araddr),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_rresp    (o_rresp),
    .o_rdata    (o_rdata),
    .bus        (reg_bus.slave)
  );

  i2c_reg_file i2c_reg_file_i (
    .clk         (clk),
    .core_reset  (core_reset),
    .bus         (reg_bus.register),
    .o_cmd       (cmd),
    .o_enable    (enable),
    .o_clk_div   (clk_div),
    .o_tx_byte   (tx_byte),
    .o_sw_clear  (sw_clear),
    .i_done      (done),
    .i_rx_ack    (rx_ack),
    .i_rx_byte   (rx_byte),
    .i_busy      (busy),
    .o_interrupt (o_interrupt)
  );

  i2c_byte_engine i2c_byte_engine_i (
    .clk        (clk),
    .core_reset (core_reset),
    .i_sw_clear (sw_clear),
    .i_enable   (enable),
    .i_clk_div  (clk_div),
    .i_cmd      (cmd),
    .i_tx_byte  (tx_byte),
    .o_done     (done),
    .o_rx_ack   (rx_ack),
    .o_rx_byte  (rx_byte),
    .o_busy     (busy),
    .o_scl_out  (o_scl_out),
    .o_scl_tri  (o_scl_tri),
    .i_scl_in   (i_scl_in),
    .o_sda_out  (o_sda_out),
    .o_sda_tri  (o_sda_tri),
    .i_sda_in   (i_sda_in)
  );

endmodule

/* bench/i2c_slave_model.sv */
// Behavioral I2C slave at address 0x50 with a 16-byte memory
// First data byte of a write sets the pointer, later bytes store
module i2c_slave_model (
  input  logic i_scl,
  input  logic i_sda,
  output logic o_sda
);

  localparam logic [6:0] OWN_ADDR = 7'h50;

  logic [7:0] mem [16];
  logic [7:0] shreg;
  logic [7:0] tx;
  logic [3:0] bit_cnt;
  logic [3:0] ptr;
  logic       in_xfer;
  logic       addr_phase;
  logic       reading;
  logic       ptr_next;
  logic       master_nack;

  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = 8'(i * 29) ^ 8'hc3;
    end
    o_sda       = 1'b1;
    in_xfer     = 1'b0;
    addr_phase  = 1'b0;
    reading     = 1'b0;
    ptr_next    = 1'b0;
    master_nack = 1'b1;
    bit_cnt     = '0;
    ptr         = '0;
    shreg       = '0;
    tx          = '0;
  end

  // START, also repeated START
  always @(negedge i_sda) begin
    if (i_scl === 1'b1) begin
      in_xfer    = 1'b1;
      addr_phase = 1'b1;
      reading    = 1'b0;
      bit_cnt    = '0;
      o_sda      = 1'b1;
    end
  end

  // STOP
  always @(posedge i_sda) begin
    if (i_scl === 1'b1) begin
      in_xfer = 1'b0;
      o_sda   = 1'b1;
    end
  end

  always @(posedge i_scl) begin
    if (in_xfer) begin
      if (bit_cnt < 4'd8) begin
        shreg   = {shreg[6:0], i_sda};
        bit_cnt = bit_cnt + 4'd1;
      end else begin
        master_nack = i_sda;
        bit_cnt     = 4'd9;
      end
    end
  end

  always @(negedge i_scl) begin
    if (in_xfer) begin
      if (bit_cnt == 4'd8) begin
        if (addr_phase) begin
          addr_phase = 1'b0;
          if (shreg[7:1] == OWN_ADDR) begin
            reading  = shreg[0];
            ptr_next = !shreg[0];
            o_sda    = 1'b0;
          end else begin
            in_xfer = 1'b0;
            o_sda   = 1'b1;
          end
        end else if (reading) begin
          // Master owns the ACK slot
          o_sda = 1'b1;
        end else begin
          if (ptr_next) begin
            ptr      = shreg[3:0];
            ptr_next = 1'b0;
          end else begin
            mem[ptr] = shreg;
            ptr      = ptr + 4'd1;
          end
          o_sda = 1'b0;
        end
      end else if (bit_cnt == 4'd9) begin
        bit_cnt = '0;
        if (reading && !master_nack) begin
          tx    = mem[ptr];
          ptr   = ptr + 4'd1;
          o_sda = tx[7];
        end else begin
          o_sda = 1'b1;
          if (reading) begin
            in_xfer = 1'b0;
          end
        end
      end else if (reading && bit_cnt != 4'd0) begin
        o_sda = tx[3'(4'd7 - bit_cnt)];
      end
    end
  end

endmodule

/* bench/tb_i2c_master.sv */
// Testbench for the AXI-Lite I2C master
// Random register and bus traffic against a slave model and a register model
module tb_i2c_master
  import i2c_pkg::*;
();

  localparam logic [6:0]  SLAVE_ADDR   = 7'h50;
  localparam logic [31:0] SEED         = 32'h7af5ac71;
  localparam int          HS_LIMIT     = 2000;
  localparam int          STATUS_POLLS = 400;

  logic                  clk;
  logic                  core_reset;
  logic                  awvalid;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  wvalid;
  logic [AXI_DATA_W-1:0] wdata;
  logic                  bready;
  logic                  arvalid;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  rready;
  logic                  awready;
  logic                  wready;
  logic                  bvalid;
  logic [1:0]            bresp;
  logic                  arready;
  logic                  rvalid;
  logic [1:0]            rresp;
  logic [AXI_DATA_W-1:0] rdata;
  logic                  scl_out;
  logic                  scl_tri;
  logic                  sda_out;
  logic                  sda_tri;
  logic                  slave_sda;
  logic                  scl;
  logic                  sda;
  logic                  irq;

  // Reference model state
  logic [7:0]       ctrl_m;
  logic [7:0]       int_en_m;
  logic [7:0]       pend_m;
  logic [7:0]       mem_m [16];
  logic [3:0]       ptr_m;

  // Open-drain wired-AND
  assign scl = scl_tri ? 1'b1 : scl_out;
  assign sda = (sda_tri ? 1'b1 : sda_out) & slave_sda;

  i2c_master_top i2c_master_top_i (
    .clk (clk), .core_reset (core_reset),
    .i_awvalid (awvalid), .i_awaddr (awaddr), .o_awready (awready),
    .i_wvalid (wvalid), .i_wdata (wdata), .o_wready (wready),
    .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
    .i_arvalid (arvalid), .i_araddr (araddr), .o_arready (arready),
    .o_rvalid (rvalid), .i_rready (rready), .o_rresp (rresp), .o_rdata (rdata),
    .o_scl_out (scl_out), .o_scl_tri (scl_tri), .i_scl_in (scl),
    .o_sda_out (sda_out), .o_sda_tri (sda_tri), .i_sda_in (sda),
    .o_interrupt (irq)
  );

  i2c_slave_model slave (.i_scl (scl), .i_sda (sda), .o_sda (slave_sda));

  always #10 clk = ~clk;

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic give_up(input string what);
    $display("Timeout waiting for %s", what);
    stop_run();
  endtask

  task automatic check_word(input string name, input logic [AXI_DATA_W-1:0] got,
                            input logic [AXI_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL o_interrupt got 0x%h expected 0x%h", got, exp);
      stop_run();
    end
  endtask

  function automatic logic expected_irq();
    return ctrl_m[CTL_IEN] & (|(pend_m & int_en_m));
  endfunction

  function automatic logic [7:0] fill_byte(input int i);
    return 8'(i * 29) ^ 8'hc3;
  endfunction

  task automatic reg_write(input logic [REG_ADDR_W-1:0] word, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    n = 0;
    awvalid <= 1'b1;
    awaddr  <= {word, 2'b00};
    wvalid  <= 1'b1;
    wdata   <= data;
    do begin
      @(posedge clk);
      n++;
      if (n > HS_LIMIT) give_up("awready or wready");
    end while (!awready && !wready);
    // Address and data channels accept together
    check_ready("o_awready", awready, 1'b1);
    check_ready("o_wready", wready, 1'b1);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    // Random gap before accepting the response
    repeat ($urandom % 4) @(posedge clk);
    bready <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > HS_LIMIT) give_up("bvalid");
    end while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic reg_read(input logic [REG_ADDR_W-1:0] word, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    n = 0;
    arvalid <= 1'b1;
    araddr  <= {word, 2'b00};
    do begin
      @(posedge clk);
      n++;
      if (n > HS_LIMIT) give_up("arready");
    end while (!arready);
    arvalid <= 1'b0;
    repeat ($urandom % 4) @(posedge clk);
    rready <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > HS_LIMIT) give_up("rvalid");
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic write_ok(input logic [REG_ADDR_W-1:0] word, input logic [31:0] data);
    logic [1:0] resp;
    reg_write(word, data, resp);
    check_resp("bresp", resp, RESP_OKAY);
  endtask

  task automatic read_expect(input string name, input logic [REG_ADDR_W-1:0] word,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    reg_read(word, data, resp);
    check_resp("rresp", resp, RESP_OKAY);
    check_word(name, data, exp);
  endtask

  // Issue one byte command and poll until the transfer ends
  task automatic run_cmd(input logic [7:0] tx, input logic [4:0] cmd, input logic exp_rxack);
    logic [31:0] status;
    logic [1:0]  resp;
    int          n;
    write_ok(REG_TRANSMIT, {24'h0, tx});
    write_ok(REG_COMMAND, {27'h0, cmd});
    n = 0;
    do begin
      reg_read(REG_STATUS, status, resp);
      check_resp("rresp", resp, RESP_OKAY);
      n++;
      if (n > STATUS_POLLS) give_up("tip to clear");
    end while (status[STS_TIP]);
    check_word("status.rxack", {31'h0, status[STS_RXACK]}, {31'h0, exp_rxack});
    pend_m[INT_DONE] = 1'b1;
    if (exp_rxack) pend_m[INT_NACK] = 1'b1;
    check_irq(irq, expected_irq());
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [7:0]  val;
    logic [6:0]  bad_addr;
    logic [4:0]  cmd;
    logic [REG_ADDR_W-1:0] bad_word;
    clk        = 1'b0;
    core_reset = 1'b1;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    void'($urandom(SEED));
    ctrl_m   = 8'h01;
    int_en_m = 8'h00;
    pend_m   = 8'h00;
    for (int i = 0; i < 16; i++) mem_m[i] = fill_byte(i);
    repeat (5) @(posedge clk);
    core_reset <= 1'b0;
    @(posedge clk);

    // Reset values
    read_expect("control", REG_CONTROL, 32'h1);
    read_expect("divider", REG_CLOCK_DIVIDER, {16'h0, DIV_100KHZ});
    read_expect("clock_rate", REG_CLOCK_RATE, CLOCK_RATE);
    read_expect("version", REG_VERSION, VERSION_WORD);
    read_expect("status", REG_STATUS, 32'h0);
    check_irq(irq, 1'b0);

    // Readback, presets and invalid addresses
    data = $urandom;
    write_ok(REG_TRANSMIT, data);
    read_expect("transmit", REG_TRANSMIT, {24'h0, data[7:0]});
    data = $urandom;
    write_ok(REG_INTERRUPT_EN, data);
    int_en_m = data[7:0];
    read_expect("interrupt_en", REG_INTERRUPT_EN, {24'h0, int_en_m});
    data = $urandom;
    write_ok(REG_CLOCK_DIVIDER, data);
    read_expect("divider", REG_CLOCK_DIVIDER, {16'h0, data[15:0]});
    write_ok(REG_CONTROL, 32'h1 | (32'h1 << CTL_SET_400K));
    read_expect("divider", REG_CLOCK_DIVIDER, {16'h0, DIV_400KHZ});
    read_expect("control", REG_CONTROL, 32'h1);
    bad_word = REG_LAST + 1 + REG_ADDR_W'($urandom % (63 - REG_LAST));
    reg_write(bad_word, $urandom, resp);
    check_resp("bresp", resp, RESP_SLVERR);
    reg_read(bad_word, data, resp);
    check_resp("rresp", resp, RESP_SLVERR);
    check_word("invalid rdata", data, 32'h0);

    // Transfer setup with a small divider
    write_ok(REG_CLOCK_DIVIDER, 2 + ($urandom % 5));
    ctrl_m = 8'h01 | (8'h1 << CTL_IEN);
    write_ok(REG_CONTROL, {24'h0, ctrl_m});
    int_en_m = (8'h1 << INT_DONE) | (8'h1 << INT_NACK);
    write_ok(REG_INTERRUPT_EN, {24'h0, int_en_m});

    // Write transfer
    run_cmd({SLAVE_ADDR, 1'b0}, 5'(1 << CMD_START) | 5'(1 << CMD_WRITE), 1'b0);
    ptr_m = 4'($urandom);
    run_cmd({4'h0, ptr_m}, 5'(1 << CMD_WRITE), 1'b0);
    for (int i = 0; i < 3; i++) begin
      val = 8'($urandom);
      cmd = 5'(1 << CMD_WRITE) | ((i == 2) ? 5'(1 << CMD_STOP) : 5'h0);
      run_cmd(val, cmd, 1'b0);
      mem_m[ptr_m] = val;
      ptr_m = ptr_m + 4'd1;
    end
    read_expect("interrupt", REG_INTERRUPT, {24'h0, pend_m});

    // Pending DONE masked by its own enable, then by the global enable
    int_en_m = 8'h1 << INT_NACK;
    write_ok(REG_INTERRUPT_EN, {24'h0, int_en_m});
    check_irq(irq, expected_irq());
    int_en_m = (8'h1 << INT_DONE) | (8'h1 << INT_NACK);
    write_ok(REG_INTERRUPT_EN, {24'h0, int_en_m});
    ctrl_m = 8'h01;
    write_ok(REG_CONTROL, {24'h0, ctrl_m});
    check_irq(irq, expected_irq());
    ctrl_m = 8'h01 | (8'h1 << CTL_IEN);
    write_ok(REG_CONTROL, {24'h0, ctrl_m});
    check_irq(irq, expected_irq());

    for (int i = 0; i < 16; i++) begin
      check_word("slave memory", {24'h0, slave.mem[i]}, {24'h0, mem_m[i]});
    end
    read_expect("status", REG_STATUS, 32'h0);
    write_ok(REG_INTERRUPT, 32'hff);
    pend_m = 8'h00;
    check_irq(irq, 1'b0);

    // Read transfer through a repeated START
    run_cmd({SLAVE_ADDR, 1'b0}, 5'(1 << CMD_START) | 5'(1 << CMD_WRITE), 1'b0);
    ptr_m = 4'($urandom);
    run_cmd({4'h0, ptr_m}, 5'(1 << CMD_WRITE), 1'b0);
    run_cmd({SLAVE_ADDR, 1'b1}, 5'(1 << CMD_START) | 5'(1 << CMD_WRITE), 1'b0);
    for (int i = 0; i < 4; i++) begin
      cmd = 5'(1 << CMD_READ);
      if (i == 3) cmd = cmd | 5'(1 << CMD_ACK) | 5'(1 << CMD_STOP);
      run_cmd(8'h00, cmd, 1'b0);
      read_expect("receive", REG_RECEIVE, {24'h0, mem_m[ptr_m]});
      ptr_m = ptr_m + 4'd1;
    end
    read_expect("status", REG_STATUS, 32'h0);

    // NACK from an absent address
    bad_addr = 7'($urandom);
    if (bad_addr == SLAVE_ADDR) bad_addr = SLAVE_ADDR + 7'd1;
    run_cmd({bad_addr, 1'b0}, 5'(1 << CMD_START) | 5'(1 << CMD_WRITE) | 5'(1 << CMD_STOP),
            1'b1);
    read_expect("interrupt", REG_INTERRUPT, {24'h0, pend_m});
    check_irq(irq, 1'b1);
    write_ok(REG_INTERRUPT, 32'hff);
    pend_m = 8'h00;
    read_expect("interrupt", REG_INTERRUPT, 32'h0);
    check_irq(irq, 1'b0);

    $display("No errors");
    $finish;
  end

endmodule

/* sim.f */
source/i2c_pkg.sv
source/reg_bus_if.sv
source/axi_lite_reg_slave.sv
source/i2c_reg_file.sv
source/i2c_byte_engine.sv
source/i2c_master_top.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
